// File: compile.f
+incdir+hdl
+incdir+tests
hdl/ntm_pkg.sv
hdl/ntm_scalar_if.sv
hdl/ntm_scalar_adder.sv
hdl/ntm_scalar_multiplier.sv
hdl/ntm_matrix_buffer.sv
hdl/ntm_matrix_transpose.sv
tests/ntm_matrix_transpose_tb.sv

// File: tests/ntm_matrix_tasks.svh
// Drive, reference and compare tasks of the transpose testbench; included inside its top module
`ifndef NTM_MATRIX_TASKS_SVH
`define NTM_MATRIX_TASKS_SVH

////////////////////
// Reporting
////////////////////

// Print the cause and stop the run
task automatic fail_stop(input string why);
  $display("%s", why);
  $display(">>> FAIL");
  $fatal(1, "simulation stopped");
endtask

task automatic check_data(input string name, input ntm_pkg::data_t got,
                          input ntm_pkg::data_t exp);
  if (got !== exp) begin
    fail_stop($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    fail_stop($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, exp));
  end
endtask

////////////////////
// Stimulus
////////////////////

// Inputs change a short delay after the rising edge
task automatic advance_cycle();
  @(posedge CLK);
  #DRIVE_DELAY;
endtask

// Random elements below the modulus
task automatic fill_matrix(input ntm_pkg::data_t modulo);
  for (int i = 0; i < `NTM_MAX_I; i++) begin
    for (int j = 0; j < `NTM_MAX_J; j++) begin
      mat[i][j] = ntm_pkg::data_t'($urandom % modulo);
    end
  end
endtask

// Start pulse followed by the matrix in row-major order
task automatic send_job(input ntm_pkg::op_t op, input ntm_pkg::data_t scalar,
                        input ntm_pkg::data_t modulo, input int ni, input int nj,
                        input bit gaps, input bit stray_start);
  int gap_len;
  advance_cycle();
  start        = 1'b1;
  operation_in = op;
  scalar_in    = scalar;
  modulo_in    = modulo;
  size_i_in    = ntm_pkg::size_t'(ni);
  size_j_in    = ntm_pkg::size_t'(nj);
  advance_cycle();
  for (int r = 0; r < ni; r++) begin
    for (int c = 0; c < nj; c++) begin
      start = 1'b0;
      gap_len = gaps ? int'($urandom_range(2, 0)) : 0;
      // Idle cycles between elements
      repeat (gap_len) begin
        data_in_j_enable = 1'b0;
        data_in_i_enable = 1'b0;
        advance_cycle();
      end
      data_in          = mat[r][c];
      data_in_j_enable = 1'b1;
      data_in_i_enable = (c == 0);
      // Second start while loading must not take effect
      if (stray_start && (r == 0) && (c == 1)) begin
        start        = 1'b1;
        operation_in = ntm_pkg::OP_SCALE;
        size_i_in    = ntm_pkg::size_t'(1);
        size_j_in    = ntm_pkg::size_t'(1);
      end
      advance_cycle();
    end
  end
  start            = 1'b0;
  data_in_j_enable = 1'b0;
  data_in_i_enable = 1'b0;
endtask

////////////////////
// Reference and collection
////////////////////

function automatic ntm_pkg::data_t ref_element(input ntm_pkg::op_t op, input ntm_pkg::data_t x,
                                               input ntm_pkg::data_t s, input ntm_pkg::data_t m);
  longint unsigned xl;
  longint unsigned sl;
  longint unsigned ml;
  xl = x;
  sl = s;
  ml = m;
  case (op)
    ntm_pkg::OP_SCALE: return ntm_pkg::data_t'((xl * sl) % ml);
    ntm_pkg::OP_ADD:   return ntm_pkg::data_t'((xl + sl) % ml);
    ntm_pkg::OP_SUB:   return ntm_pkg::data_t'((xl + ml - sl) % ml);
    default:           return x;
  endcase
endfunction

// Output (r, c) compared with input (c, r) before the ready pulse
task automatic collect_result(input ntm_pkg::op_t op, input ntm_pkg::data_t scalar,
                              input ntm_pkg::data_t modulo, input int ni, input int nj);
  int r;
  int c;
  int wait_cycles;
  r = 0;
  c = 0;
  while (r < nj) begin
    wait_cycles = 0;
    while (data_out_j_enable !== 1'b1) begin
      check_flag("ready", ready, 1'b0);
      if (wait_cycles == ELEM_TIMEOUT) begin
        fail_stop($sformatf("Timed out waiting for output element row %0d col %0d", r, c));
      end else begin
        wait_cycles++;
        advance_cycle();
      end
    end
    check_data("data_out", data_out, ref_element(op, mat[c][r], scalar, modulo));
    check_flag("data_out_i_enable", data_out_i_enable, logic'(c == 0));
    check_flag("ready", ready, 1'b0);
    advance_cycle();
    c++;
    if (c == ni) begin
      c = 0;
      r++;
    end
  end
  wait_cycles = 0;
  while (ready !== 1'b1) begin
    // No element beyond the last one
    check_flag("data_out_j_enable", data_out_j_enable, 1'b0);
    if (wait_cycles == READY_TIMEOUT) begin
      fail_stop("Timed out waiting for ready after the last output element");
    end else begin
      wait_cycles++;
      advance_cycle();
    end
  end
  check_flag("data_out_j_enable", data_out_j_enable, 1'b0);
endtask

task automatic run_job(input ntm_pkg::op_t op, input ntm_pkg::data_t scalar,
                       input ntm_pkg::data_t modulo, input int ni, input int nj,
                       input bit gaps, input bit stray_start);
  send_job(op, scalar, modulo, ni, nj, gaps, stray_start);
  collect_result(op, scalar, modulo, ni, nj);
endtask

`endif

// File: tests/ntm_matrix_transpose_tb.sv
// Directed testbench of the transpose unit; top module of the simulation built from compile.f
`timescale 1ns/10ps
`include "ntm_config.svh"

module ntm_matrix_transpose_tb;

  // Input drive offset after the rising edge
  localparam int DRIVE_DELAY = 10;
  // Multiplier latency with margin
  localparam int ELEM_TIMEOUT  = 4 * `NTM_DATA_SIZE + 16;
  localparam int READY_TIMEOUT = 8;
  localparam ntm_pkg::data_t PRIME = 16'hfff1;

  logic           CLK;
  logic           RST;
  logic           start;
  logic           ready;
  ntm_pkg::op_t   operation_in;
  ntm_pkg::data_t scalar_in;
  ntm_pkg::data_t modulo_in;
  ntm_pkg::data_t data_in;
  ntm_pkg::size_t size_i_in;
  ntm_pkg::size_t size_j_in;
  logic           data_in_i_enable;
  logic           data_in_j_enable;
  logic           data_out_i_enable;
  logic           data_out_j_enable;
  ntm_pkg::data_t data_out;

  // Matrix of the current job, row-major as sent
  ntm_pkg::data_t mat [`NTM_MAX_I][`NTM_MAX_J];

  ntm_matrix_transpose u_ntm_matrix_transpose (
    .CLK               (CLK),
    .RST               (RST),
    .start             (start),
    .ready             (ready),
    .operation_in      (operation_in),
    .scalar_in         (scalar_in),
    .modulo_in         (modulo_in),
    .size_i_in         (size_i_in),
    .size_j_in         (size_j_in),
    .data_in           (data_in),
    .data_in_i_enable  (data_in_i_enable),
    .data_in_j_enable  (data_in_j_enable),
    .data_out_i_enable (data_out_i_enable),
    .data_out_j_enable (data_out_j_enable),
    .data_out          (data_out)
  );

  // 100 ns clock
  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  `include "ntm_matrix_tasks.svh"

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic test_reset_values();
    check_flag("ready", ready, 1'b0);
    check_flag("data_out_i_enable", data_out_i_enable, 1'b0);
    check_flag("data_out_j_enable", data_out_j_enable, 1'b0);
    check_data("data_out", data_out, '0);
  endtask

  task automatic test_square_transpose();
    fill_matrix(PRIME);
    run_job(ntm_pkg::OP_TRANSPOSE, '0, PRIME, 4, 4, 1'b0, 1'b0);
  endtask

  // 2x3 with gaps and a stray start, then a single row
  task automatic test_rect_transpose();
    fill_matrix(PRIME);
    run_job(ntm_pkg::OP_TRANSPOSE, '0, PRIME, 2, 3, 1'b1, 1'b1);
    fill_matrix(PRIME);
    run_job(ntm_pkg::OP_TRANSPOSE, '0, PRIME, 1, 4, 1'b0, 1'b0);
  endtask

  task automatic test_scale();
    ntm_pkg::data_t scalar;
    fill_matrix(PRIME);
    scalar = ntm_pkg::data_t'($urandom % PRIME);
    run_job(ntm_pkg::OP_SCALE, scalar, PRIME, 3, 3, 1'b0, 1'b0);
  endtask

  task automatic test_add_sub();
    // Large scalar, nearly every sum wraps
    fill_matrix(PRIME);
    mat[0][0] = '0;
    mat[1][1] = PRIME - 1'b1;
    run_job(ntm_pkg::OP_ADD, PRIME - 16'd7, PRIME, 4, 4, 1'b0, 1'b0);
    // Small modulus, about half the differences borrow
    fill_matrix(16'd1000);
    mat[0][0] = '0;
    mat[2][3] = 16'd999;
    run_job(ntm_pkg::OP_SUB, 16'd500, 16'd1000, 4, 4, 1'b0, 1'b0);
  endtask

  ////////////////////
  // Sequence
  ////////////////////

  initial begin
    void'($urandom(32'hbd07314c));
    RST              = 1'b1;
    start            = 1'b0;
    operation_in     = ntm_pkg::OP_TRANSPOSE;
    scalar_in        = '0;
    modulo_in        = '0;
    data_in          = '0;
    size_i_in        = '0;
    size_j_in        = '0;
    data_in_i_enable = 1'b0;
    data_in_j_enable = 1'b0;
    repeat (3) @(posedge CLK);
    #DRIVE_DELAY;
    RST = 1'b0;
    test_reset_values();
    test_square_transpose();
    test_rect_transpose();
    test_scale();
    test_add_sub();
    $display(">>> PASS");
    $finish;
  end

endmodule

// File: hdl/ntm_matrix_transpose.sv
// Top of the transpose unit; loads a matrix row-major and streams out its transpose, optionally scaled
`timescale 1ns/10ps
`include "ntm_config.svh"

module ntm_matrix_transpose (
  input  logic            CLK,
  input  logic            RST,

  // Control
  input  logic            start,
  output logic            ready,
  input  ntm_pkg::op_t    operation_in,

  // Operands and sizes, latched on start
  input  ntm_pkg::data_t  scalar_in,
  input  ntm_pkg::data_t  modulo_in,
  input  ntm_pkg::size_t  size_i_in,
  input  ntm_pkg::size_t  size_j_in,

  // Input stream
  input  ntm_pkg::data_t  data_in,
  input  logic            data_in_i_enable,
  input  logic            data_in_j_enable,

  // Output stream
  output logic            data_out_i_enable,
  output logic            data_out_j_enable,
  output ntm_pkg::data_t  data_out
);

  typedef enum logic [2:0] {ST_IDLE, ST_LOAD, ST_READ, ST_COMPUTE, ST_EMIT} state_t;

  state_t state;

  // Job registers
  ntm_pkg::op_t   op_r;
  ntm_pkg::data_t scalar_r;
  ntm_pkg::data_t modulo_r;
  ntm_pkg::size_t size_i_r;
  ntm_pkg::size_t size_j_r;

  // Load position, row and column of the input
  ntm_pkg::size_t in_row;
  ntm_pkg::size_t in_col;
  ntm_pkg::size_t col_cur;

  // Emit position, row and column of the transpose
  ntm_pkg::size_t out_row;
  ntm_pkg::size_t out_col;
  logic           out_last;
  logic           last_pos;

  // Buffer ports
  logic           wr_enable;
  ntm_pkg::addr_t wr_addr;
  ntm_pkg::addr_t rd_addr;
  ntm_pkg::data_t rd_data;

  // Scalar unit selection
  logic           unit_wait;
  logic           unit_ready;
  ntm_pkg::data_t unit_result;
  logic           emit_now;
  ntm_pkg::data_t emit_value;

  ntm_scalar_if add_bus ();
  ntm_scalar_if mul_bus ();

  ////////////////////
  // Addressing
  ////////////////////

  // Row start forces column back to zero
  assign col_cur   = data_in_i_enable ? '0 : in_col;
  assign wr_enable = (state == ST_LOAD) && data_in_j_enable;
  assign wr_addr   = ntm_pkg::addr_t'(in_row * `NTM_MAX_J + col_cur);

  // Output (r, c) is input (c, r)
  assign rd_addr  = ntm_pkg::addr_t'(out_col * `NTM_MAX_J + out_row);
  assign last_pos = (out_row == size_j_r - 1'b1) && (out_col == size_i_r - 1'b1);

  ////////////////////
  // Scalar units
  ////////////////////

  // Both units see the same operands, only one gets a start
  assign add_bus.start     = (state == ST_COMPUTE) && !unit_wait &&
                             ((op_r == ntm_pkg::OP_ADD) || (op_r == ntm_pkg::OP_SUB));
  assign add_bus.operation = (op_r == ntm_pkg::OP_SUB);
  assign add_bus.modulo    = modulo_r;
  assign add_bus.data_a    = rd_data;
  assign add_bus.data_b    = scalar_r;

  assign mul_bus.start     = (state == ST_COMPUTE) && !unit_wait && (op_r == ntm_pkg::OP_SCALE);
  assign mul_bus.operation = 1'b0;
  assign mul_bus.modulo    = modulo_r;
  assign mul_bus.data_a    = rd_data;
  assign mul_bus.data_b    = scalar_r;

  assign unit_ready  = (op_r == ntm_pkg::OP_SCALE) ? mul_bus.ready : add_bus.ready;
  assign unit_result = (op_r == ntm_pkg::OP_SCALE) ? mul_bus.data_out : add_bus.data_out;

  // Plain transpose goes straight through
  assign emit_now   = (state == ST_COMPUTE) &&
                      ((op_r == ntm_pkg::OP_TRANSPOSE) || (unit_wait && unit_ready));
  assign emit_value = (op_r == ntm_pkg::OP_TRANSPOSE) ? rd_data : unit_result;

  ////////////////////
  // Control FSM
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state             <= ST_IDLE;
      ready             <= 1'b0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
      data_out          <= '0;
      op_r              <= ntm_pkg::OP_TRANSPOSE;
      scalar_r          <= '0;
      modulo_r          <= '0;
      size_i_r          <= '0;
      size_j_r          <= '0;
      in_row            <= '0;
      in_col            <= '0;
      out_row           <= '0;
      out_col           <= '0;
      out_last          <= 1'b0;
      unit_wait         <= 1'b0;
    end else begin
      // Pulses by default
      ready             <= 1'b0;
      data_out_i_enable <= 1'b0;
      data_out_j_enable <= 1'b0;
      case (state)
        ST_IDLE: begin
          // Start ignored anywhere else
          if (start) begin
            op_r     <= operation_in;
            scalar_r <= scalar_in;
            modulo_r <= modulo_in;
            size_i_r <= size_i_in;
            size_j_r <= size_j_in;
            in_row   <= '0;
            in_col   <= '0;
            out_row  <= '0;
            out_col  <= '0;
            out_last <= 1'b0;
            state    <= ST_LOAD;
          end
        end
        ST_LOAD: begin
          if (data_in_j_enable) begin
            if (col_cur == size_j_r - 1'b1) begin
              // End of an input row
              in_col <= '0;
              in_row <= in_row + 1'b1;
              if (in_row == size_i_r - 1'b1) begin
                state <= ST_READ;
              end
            end else begin
              in_col <= col_cur + 1'b1;
            end
          end
        end
        // Address of the first element on the buffer
        ST_READ: begin
          state <= ST_COMPUTE;
        end
        ST_COMPUTE: begin
          if ((op_r != ntm_pkg::OP_TRANSPOSE) && !unit_wait) begin
            unit_wait <= 1'b1;
          end
          if (emit_now) begin
            unit_wait         <= 1'b0;
            data_out          <= emit_value;
            data_out_j_enable <= 1'b1;
            data_out_i_enable <= (out_col == '0);
            out_last          <= last_pos;
            // Step to the next output position
            if (out_col == size_i_r - 1'b1) begin
              out_col <= '0;
              out_row <= out_row + 1'b1;
            end else begin
              out_col <= out_col + 1'b1;
            end
            state <= ST_EMIT;
          end
        end
        // Element on the outputs, next read in flight
        ST_EMIT: begin
          if (out_last) begin
            ready <= 1'b1;
            state <= ST_IDLE;
          end else begin
            state <= ST_COMPUTE;
          end
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // Instances
  ////////////////////

  ntm_matrix_buffer u_ntm_matrix_buffer (
    .CLK       (CLK),
    .wr_enable (wr_enable),
    .wr_addr   (wr_addr),
    .wr_data   (data_in),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  ntm_scalar_adder u_ntm_scalar_adder (
    .CLK (CLK),
    .RST (RST),
    .bus (add_bus)
  );

  ntm_scalar_multiplier u_ntm_scalar_multiplier (
    .CLK (CLK),
    .RST (RST),
    .bus (mul_bus)
  );

endmodule

// File: hdl/ntm_matrix_buffer.sv
// Element store for one matrix; row-major writes from the loader, addressed registered reads
`timescale 1ns/10ps
`include "ntm_config.svh"

module ntm_matrix_buffer (
  input  logic           CLK,

  // Write port
  input  logic           wr_enable,
  input  ntm_pkg::addr_t wr_addr,
  input  ntm_pkg::data_t wr_data,

  // Read port, data one cycle after address
  input  ntm_pkg::addr_t rd_addr,
  output ntm_pkg::data_t rd_data
);

  ////////////////////
  // Storage
  ////////////////////

  // Row r, column c lives at r*NTM_MAX_J + c
  ntm_pkg::data_t mem [`NTM_MAX_I*`NTM_MAX_J];

  ////////////////////
  // Write
  ////////////////////

  always_ff @(posedge CLK) begin
    if (wr_enable) begin
      mem[wr_addr] <= wr_data;
    end
  end

  ////////////////////
  // Read
  ////////////////////

  // Read every cycle
  // Controller holds the address while it needs the data
  always_ff @(posedge CLK) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// File: hdl/ntm_scalar_multiplier.sv
// Bit-serial interleaved modular multiplier; one operand bit per cycle behind a scalar interface
`timescale 1ns/10ps
`include "ntm_config.svh"

module ntm_scalar_multiplier (
  input logic CLK,
  input logic RST,
  ntm_scalar_if.slave bus
);

  // Steps remaining, counts down to zero
  typedef logic [$clog2(`NTM_DATA_SIZE)-1:0] count_t;
  typedef logic [`NTM_DATA_SIZE:0] wide_t;

  // Control
  logic busy;
  count_t bit_count;

  // Operand and accumulator registers
  ntm_pkg::data_t acc;
  ntm_pkg::data_t op_a;
  ntm_pkg::data_t op_b;
  ntm_pkg::data_t modulus;

  // One step of the recurrence
  wide_t dbl;
  wide_t dbl_red;
  wide_t sum;
  ntm_pkg::data_t acc_next;

  ////////////////////
  // Step logic
  ////////////////////

  // acc = 2*acc + b[i]*a, reduced after each part
  always_comb begin
    dbl     = {acc, 1'b0};
    dbl_red = (dbl >= {1'b0, modulus}) ? dbl - {1'b0, modulus} : dbl;
    // Scan b from the MSB
    if (op_b[`NTM_DATA_SIZE-1]) begin
      sum = dbl_red + {1'b0, op_a};
    end else begin
      sum = dbl_red;
    end
    if (sum >= {1'b0, modulus}) begin
      acc_next = ntm_pkg::data_t'(sum - {1'b0, modulus});
    end else begin
      acc_next = ntm_pkg::data_t'(sum);
    end
  end

  // Operands latched on start, then one step per cycle
  always_ff @(posedge CLK) begin
    if (bus.start) begin
      op_a    <= bus.data_a;
      op_b    <= bus.data_b;
      modulus <= bus.modulo;
      acc     <= '0;
    end else if (busy) begin
      acc  <= acc_next;
      op_b <= op_b << 1;
      // Last step lands straight in the output register
      if (bit_count == '0) begin
        bus.data_out <= acc_next;
      end
    end
  end

  ////////////////////
  // Sequencing
  ////////////////////

  // NTM_DATA_SIZE steps, ready right after the last one
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy      <= 1'b0;
      bit_count <= '0;
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= 1'b0;
      if (bus.start) begin
        busy      <= 1'b1;
        bit_count <= count_t'(`NTM_DATA_SIZE - 1);
      end else if (busy) begin
        if (bit_count == '0) begin
          busy      <= 1'b0;
          bus.ready <= 1'b1;
        end else begin
          bit_count <= bit_count - 1'b1;
        end
      end
    end
  end

endmodule

// File: hdl/ntm_scalar_adder.sv
// Modular adder/subtractor with one cycle of latency; served through a scalar interface
`timescale 1ns/10ps
`include "ntm_config.svh"

module ntm_scalar_adder (
  input logic CLK,
  input logic RST,
  ntm_scalar_if.slave bus
);

  // One extra bit for carry or borrow
  typedef logic [`NTM_DATA_SIZE:0] wide_t;

  wide_t sum;
  wide_t diff;
  wide_t modulus;
  ntm_pkg::data_t result;

  ////////////////////
  // Datapath
  ////////////////////

  always_comb begin
    modulus = {1'b0, bus.modulo};
    sum     = {1'b0, bus.data_a} + {1'b0, bus.data_b};
    diff    = {1'b0, bus.data_a} - {1'b0, bus.data_b};
    if (bus.operation) begin
      // Borrow set, wrap back up by one modulus
      result = diff[`NTM_DATA_SIZE] ? ntm_pkg::data_t'(diff + modulus) : ntm_pkg::data_t'(diff);
    end else begin
      // Sum below 2*modulo, one subtraction is enough
      result = (sum >= modulus) ? ntm_pkg::data_t'(sum - modulus) : ntm_pkg::data_t'(sum);
    end
  end

  // Result register
  always_ff @(posedge CLK) begin
    if (bus.start) begin
      bus.data_out <= result;
    end
  end

  ////////////////////
  // Handshake
  ////////////////////

  // Ready one cycle behind start
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      bus.ready <= 1'b0;
    end else begin
      bus.ready <= bus.start;
    end
  end

endmodule

// File: hdl/ntm_scalar_if.sv
// Request/result link between the transpose controller and one modular scalar unit
`timescale 1ns/10ps

interface ntm_scalar_if;

  // Handshake
  // One-cycle start latches operands, one-cycle ready returns result
  logic start;
  logic ready;

  // 0 add, 1 subtract; adder only
  logic operation;

  // Operands, both already below modulo
  ntm_pkg::data_t modulo;
  ntm_pkg::data_t data_a;
  ntm_pkg::data_t data_b;

  // Result, valid while ready is high
  ntm_pkg::data_t data_out;

  // Controller side
  modport master (
    output start,
    output operation,
    output modulo,
    output data_a,
    output data_b,
    input  ready,
    input  data_out
  );

  // Arithmetic unit side
  modport slave (
    input  start,
    input  operation,
    input  modulo,
    input  data_a,
    input  data_b,
    output ready,
    output data_out
  );

endinterface

// File: hdl/ntm_pkg.sv
// Shared types of the transpose unit; referenced by scoped name from the RTL and testbench
`include "ntm_config.svh"

package ntm_pkg;

  ////////////////////
  // Data types
  ////////////////////

  // One element, modulus or scalar
  typedef logic [`NTM_DATA_SIZE-1:0] data_t;

  // Row or column count, 1 to the maximum
  typedef logic [`NTM_SIZE_BITS-1:0] size_t;

  // Index into the element store
  typedef logic [`NTM_ADDR_SIZE-1:0] addr_t;

  // Operation applied on the way out
  typedef enum logic [1:0] {
    OP_TRANSPOSE = 2'd0,
    OP_SCALE     = 2'd1,
    OP_ADD       = 2'd2,
    OP_SUB       = 2'd3
  } op_t;

endpackage

// File: hdl/ntm_config.svh
// Build-time sizes of the transpose unit; include wherever element or matrix widths are needed
`ifndef NTM_CONFIG_SVH
`define NTM_CONFIG_SVH

////////////////////
// Element width
////////////////////

// Width of an element, of the modulus and of the scalar
`define NTM_DATA_SIZE 16

////////////////////
// Matrix limits
////////////////////

// Largest row and column counts
`define NTM_MAX_I 4
`define NTM_MAX_J 4

// Buffer index, enough for NTM_MAX_I x NTM_MAX_J
`define NTM_ADDR_SIZE 4
// Run-time size input, holds 1 up to the maximum
`define NTM_SIZE_BITS 3

`endif
